// File: verilog/mips_pkg.sv
package mips_pkg;

  // opcodes
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_J     = 6'h02;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_BNE   = 6'h05;
  localparam logic [5:0] OP_ADDI  = 6'h08;
  localparam logic [5:0] OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_LUI   = 6'h0f;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2b;

  // r-type funct field
  localparam logic [5:0] FN_ADD = 6'h20;
  localparam logic [5:0] FN_SUB = 6'h22;
  localparam logic [5:0] FN_AND = 6'h24;
  localparam logic [5:0] FN_OR  = 6'h25;
  localparam logic [5:0] FN_SLT = 6'h2a;

  typedef struct packed {
    logic       reg_dst;
    logic       jump;
    logic       beq;
    logic       bne;
    logic       mem_to_reg;
    logic [5:0] alu_op;
    logic       mem_write;
    logic       alu_src;
    logic       reg_write;
    logic       ext_op;
  } ctrl_t;

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc_plus4;
  } if_id_t;

  typedef struct packed {
    ctrl_t       ctrl;
    logic [31:0] pc_plus4;
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic [31:0] imm;
    logic [5:0]  funct;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [25:0] jidx;
  } id_ex_t;

  typedef struct packed {
    logic        mem_to_reg;
    logic        mem_write;
    logic        reg_write;
    logic [31:0] result;
    logic [31:0] store_data;
    logic [4:0]  dst;
  } ex_mem_t;

  typedef struct packed {
    logic        reg_write;
    logic [4:0]  dst;
    logic [31:0] data;
  } mem_wb_t;

endpackage

// File: verilog/control.sv
`timescale 1ns/10ps

module control
(
  input  logic [5:0]      i_instr_code,
  output mips_pkg::ctrl_t o_ctrl
);
  import mips_pkg::*;

  always_comb
  begin
    // unknown opcodes decode to a bubble
    o_ctrl = '0;
    case (i_instr_code)
      OP_RTYPE:
      begin
        o_ctrl.reg_dst   = 1'b1;
        o_ctrl.reg_write = 1'b1;
        o_ctrl.alu_op    = i_instr_code;
      end
      OP_ADDI, OP_ADDIU, OP_LUI:
      begin
        o_ctrl.reg_write = 1'b1;
        o_ctrl.alu_src   = 1'b1;
        o_ctrl.alu_op    = i_instr_code;
        o_ctrl.ext_op    = 1'b1;
      end
      OP_LW:
      begin
        o_ctrl.reg_write  = 1'b1;
        o_ctrl.alu_src    = 1'b1;
        o_ctrl.mem_to_reg = 1'b1;
        o_ctrl.alu_op     = i_instr_code;
        o_ctrl.ext_op     = 1'b1;
      end
      OP_SW:
      begin
        o_ctrl.mem_write = 1'b1;
        o_ctrl.alu_src   = 1'b1;
        o_ctrl.alu_op    = i_instr_code;
        o_ctrl.ext_op    = 1'b1;
      end
      OP_J:
      begin
        o_ctrl.jump   = 1'b1;
        o_ctrl.alu_op = i_instr_code;
      end
      OP_BEQ:
      begin
        o_ctrl.beq    = 1'b1;
        o_ctrl.alu_op = i_instr_code;
      end
      OP_BNE:
      begin
        o_ctrl.bne    = 1'b1;
        o_ctrl.alu_op = i_instr_code;
      end
      default:
      begin
        o_ctrl = '0;
      end
    endcase
  end

endmodule

// File: verilog/pipe_reg.sv
`timescale 1ns/10ps

module pipe_reg #(
  parameter type T = logic [31:0]
)
(
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_stall,
  input  logic i_flush,
  input  T     i_d,
  output T     o_q
);

  // flush wins over stall
  always_ff @(posedge i_clk)
  begin
    if (i_rst || i_flush)
      o_q <= '0;
    else if (!i_stall)
      o_q <= i_d;
  end

endmodule

// File: verilog/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage #(
  parameter int IMEM_WORDS = 64
)
(
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  logic                          i_run,
  input  logic                          i_stall,
  input  logic                          i_redirect,
  input  logic [31:0]                   i_target,
  input  logic                          i_imem_we,
  input  logic [$clog2(IMEM_WORDS)-1:0] i_imem_addr,
  input  logic [31:0]                   i_imem_data,
  output mips_pkg::if_id_t              o_if_id,
  output logic [31:0]                   o_pc
);
  localparam int IA = $clog2(IMEM_WORDS);

  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] pc;
  logic [31:0] pc_plus4;

  assign pc_plus4 = pc + 32'd4;
  assign o_pc     = pc;

  always_ff @(posedge i_clk)
  begin
    if (i_rst)
      pc <= '0;
    else if (i_redirect)
      pc <= i_target;
    else if (i_run && !i_stall)
      pc <= pc_plus4;
  end

  // program load port
  always_ff @(posedge i_clk)
  begin
    if (i_imem_we)
      imem[i_imem_addr] <= i_imem_data;
  end

  always_comb
  begin
    o_if_id = '0;
    if (i_run)
    begin
      o_if_id.instr    = imem[pc[IA+1:2]];
      o_if_id.pc_plus4 = pc_plus4;
    end
  end

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/10ps

module decode_stage
(
  input  logic              i_clk,
  input  logic              i_rst,
  input  mips_pkg::if_id_t  i_if_id,
  input  mips_pkg::mem_wb_t i_wb,
  input  logic [4:0]        i_ex_dst,
  input  logic              i_ex_we,
  input  logic [4:0]        i_mem_dst,
  input  logic              i_mem_we,
  input  logic [4:0]        i_dbg_reg,
  output mips_pkg::id_ex_t  o_id_ex,
  output logic              o_stall,
  output logic [31:0]       o_dbg_reg_data
);
  import mips_pkg::*;

  logic [31:0] regs [32];
  ctrl_t       ctrl;
  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [4:0]  rd;
  logic [15:0] imm16;
  logic [31:0] imm_ext;
  logic [31:0] rs_val;
  logic [31:0] rt_val;
  logic        rs_used;
  logic        rt_used;

  // writeback data passes straight through to the read ports
  function automatic logic [31:0] rf_read(input logic [4:0] addr);
    logic [31:0] val;
    if (addr == 5'd0)
      val = '0;
    else if (i_wb.reg_write && i_wb.dst == addr)
      val = i_wb.data;
    else
      val = regs[addr];
    return val;
  endfunction

  function automatic logic pending(input logic [4:0] src);
    logic hit;
    hit = (i_ex_we && i_ex_dst == src) || (i_mem_we && i_mem_dst == src);
    return (src != 5'd0) && hit;
  endfunction

  assign rs    = i_if_id.instr[25:21];
  assign rt    = i_if_id.instr[20:16];
  assign rd    = i_if_id.instr[15:11];
  assign imm16 = i_if_id.instr[15:0];

  control u_control
  (
    .i_instr_code (i_if_id.instr[31:26]),
    .o_ctrl       (ctrl)
  );

  always_ff @(posedge i_clk)
  begin
    if (!i_rst && i_wb.reg_write && i_wb.dst != 5'd0)
      regs[i_wb.dst] <= i_wb.data;
  end

  always_comb
  begin
    rs_val         = rf_read(rs);
    rt_val         = rf_read(rt);
    o_dbg_reg_data = rf_read(i_dbg_reg);
  end

  // branch offsets are always signed
  always_comb
  begin
    if (ctrl.alu_op == OP_LUI)
      imm_ext = {imm16, 16'h0000};
    else if (ctrl.ext_op || ctrl.beq || ctrl.bne)
      imm_ext = {{16{imm16[15]}}, imm16};
    else
      imm_ext = {16'h0000, imm16};
  end

  // which source fields are real operands
  assign rs_used = ctrl.reg_write | ctrl.mem_write | ctrl.beq | ctrl.bne;
  assign rt_used = ctrl.reg_dst | ctrl.mem_write | ctrl.beq | ctrl.bne;

  always_comb
  begin
    o_stall = (rs_used && pending(rs)) || (rt_used && pending(rt));
  end

  // a stalled instruction leaves a bubble behind it
  always_comb
  begin
    o_id_ex = '0;
    if (!o_stall)
    begin
      o_id_ex.ctrl     = ctrl;
      o_id_ex.pc_plus4 = i_if_id.pc_plus4;
      o_id_ex.rs_val   = rs_val;
      o_id_ex.rt_val   = rt_val;
      o_id_ex.imm      = imm_ext;
      o_id_ex.funct    = i_if_id.instr[5:0];
      o_id_ex.rt       = rt;
      o_id_ex.rd       = rd;
      o_id_ex.jidx     = i_if_id.instr[25:0];
    end
  end

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/10ps

module execute_stage
(
  input  mips_pkg::id_ex_t  i_id_ex,
  output mips_pkg::ex_mem_t o_ex_mem,
  output logic              o_redirect,
  output logic [31:0]       o_target,
  output logic [4:0]        o_dst,
  output logic              o_we
);
  import mips_pkg::*;

  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] result;
  logic        equal;
  logic        taken;
  logic [31:0] br_target;
  logic [31:0] j_target;

  assign op_a = i_id_ex.rs_val;
  assign op_b = i_id_ex.ctrl.alu_src ? i_id_ex.imm : i_id_ex.rt_val;

  always_comb
  begin
    result = op_a + op_b;
    if (i_id_ex.ctrl.alu_op == OP_RTYPE)
    begin
      case (i_id_ex.funct)
        FN_ADD:  result = op_a + op_b;
        FN_SUB:  result = op_a - op_b;
        FN_AND:  result = op_a & op_b;
        FN_OR:   result = op_a | op_b;
        FN_SLT:  result = {31'b0, $signed(op_a) < $signed(op_b)};
        default: result = '0;
      endcase
    end
    else if (i_id_ex.ctrl.alu_op == OP_LUI)
    begin
      // immediate already sits in the upper half
      result = op_b;
    end
  end

  assign equal     = (i_id_ex.rs_val == i_id_ex.rt_val);
  assign taken     = (i_id_ex.ctrl.beq && equal) || (i_id_ex.ctrl.bne && !equal);
  assign br_target = i_id_ex.pc_plus4 + {i_id_ex.imm[29:0], 2'b00};
  assign j_target  = {i_id_ex.pc_plus4[31:28], i_id_ex.jidx, 2'b00};

  assign o_redirect = taken || i_id_ex.ctrl.jump;
  assign o_target   = i_id_ex.ctrl.jump ? j_target : br_target;

  assign o_dst = i_id_ex.ctrl.reg_dst ? i_id_ex.rd : i_id_ex.rt;
  assign o_we  = i_id_ex.ctrl.reg_write;

  always_comb
  begin
    o_ex_mem.mem_to_reg = i_id_ex.ctrl.mem_to_reg;
    o_ex_mem.mem_write  = i_id_ex.ctrl.mem_write;
    o_ex_mem.reg_write  = i_id_ex.ctrl.reg_write;
    o_ex_mem.result     = result;
    o_ex_mem.store_data = i_id_ex.rt_val;
    o_ex_mem.dst        = o_dst;
  end

endmodule

// File: verilog/memory_stage.sv
`timescale 1ns/10ps

module memory_stage #(
  parameter int DMEM_WORDS = 64
)
(
  input  logic                          i_clk,
  input  mips_pkg::ex_mem_t             i_ex_mem,
  input  logic [$clog2(DMEM_WORDS)-1:0] i_dbg_mem,
  output mips_pkg::mem_wb_t             o_mem_wb,
  output logic [4:0]                    o_dst,
  output logic                          o_we,
  output logic [31:0]                   o_dbg_mem_data
);
  localparam int DA = $clog2(DMEM_WORDS);

  logic [31:0]   dmem [DMEM_WORDS];
  logic [DA-1:0] addr;
  logic [31:0]   load_data;

  // word addressed
  assign addr = i_ex_mem.result[DA+1:2];

  always_ff @(posedge i_clk)
  begin
    if (i_ex_mem.mem_write)
      dmem[addr] <= i_ex_mem.store_data;
  end

  assign load_data      = dmem[addr];
  assign o_dbg_mem_data = dmem[i_dbg_mem];

  assign o_dst = i_ex_mem.dst;
  assign o_we  = i_ex_mem.reg_write;

  always_comb
  begin
    o_mem_wb.reg_write = i_ex_mem.reg_write;
    o_mem_wb.dst       = i_ex_mem.dst;
    o_mem_wb.data      = i_ex_mem.mem_to_reg ? load_data : i_ex_mem.result;
  end

endmodule

// File: verilog/mips_core.sv
`timescale 1ns/10ps

module mips_core #(
  parameter int IMEM_WORDS = 64,
  parameter int DMEM_WORDS = 64
)
(
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  logic                          i_run,
  input  logic                          i_imem_we,
  input  logic [$clog2(IMEM_WORDS)-1:0] i_imem_addr,
  input  logic [31:0]                   i_imem_data,
  input  logic [4:0]                    i_dbg_reg,
  output logic [31:0]                   o_dbg_reg_data,
  input  logic [$clog2(DMEM_WORDS)-1:0] i_dbg_mem,
  output logic [31:0]                   o_dbg_mem_data,
  output logic [31:0]                   o_pc
);
  import mips_pkg::*;

  if_id_t      if_d;
  if_id_t      if_q;
  id_ex_t      id_d;
  id_ex_t      id_q;
  ex_mem_t     ex_d;
  ex_mem_t     ex_q;
  mem_wb_t     mem_d;
  mem_wb_t     wb_q;
  logic        stall;
  logic        redirect;
  logic [31:0] target;
  logic [4:0]  ex_dst;
  logic        ex_we;
  logic [4:0]  mem_dst;
  logic        mem_we;

  fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) u_fetch
  (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_run       (i_run),
    .i_stall     (stall),
    .i_redirect  (redirect),
    .i_target    (target),
    .i_imem_we   (i_imem_we),
    .i_imem_addr (i_imem_addr),
    .i_imem_data (i_imem_data),
    .o_if_id     (if_d),
    .o_pc        (o_pc)
  );

  pipe_reg #(.T(if_id_t)) u_if_id
  (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_stall (stall),
    .i_flush (redirect),
    .i_d     (if_d),
    .o_q     (if_q)
  );

  decode_stage u_decode
  (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_if_id        (if_q),
    .i_wb           (wb_q),
    .i_ex_dst       (ex_dst),
    .i_ex_we        (ex_we),
    .i_mem_dst      (mem_dst),
    .i_mem_we       (mem_we),
    .i_dbg_reg      (i_dbg_reg),
    .o_id_ex        (id_d),
    .o_stall        (stall),
    .o_dbg_reg_data (o_dbg_reg_data)
  );

  // decode already turns a stall into a bubble
  pipe_reg #(.T(id_ex_t)) u_id_ex
  (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_stall (1'b0),
    .i_flush (redirect),
    .i_d     (id_d),
    .o_q     (id_q)
  );

  execute_stage u_execute
  (
    .i_id_ex    (id_q),
    .o_ex_mem   (ex_d),
    .o_redirect (redirect),
    .o_target   (target),
    .o_dst      (ex_dst),
    .o_we       (ex_we)
  );

  pipe_reg #(.T(ex_mem_t)) u_ex_mem
  (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_stall (1'b0),
    .i_flush (1'b0),
    .i_d     (ex_d),
    .o_q     (ex_q)
  );

  memory_stage #(.DMEM_WORDS(DMEM_WORDS)) u_memory
  (
    .i_clk          (i_clk),
    .i_ex_mem       (ex_q),
    .i_dbg_mem      (i_dbg_mem),
    .o_mem_wb       (mem_d),
    .o_dst          (mem_dst),
    .o_we           (mem_we),
    .o_dbg_mem_data (o_dbg_mem_data)
  );

  pipe_reg #(.T(mem_wb_t)) u_mem_wb
  (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_stall (1'b0),
    .i_flush (1'b0),
    .i_d     (mem_d),
    .o_q     (wb_q)
  );

endmodule

// File: tests/mips_core_chk.sv
`timescale 1ns/10ps

module mips_core_chk
(
  input logic        i_clk,
  input logic        i_rst,
  input logic        i_mem_write,
  input logic        i_redirect,
  input logic [31:0] i_target,
  input logic [31:0] i_pc,
  input logic [4:0]  i_dbg_reg,
  input logic [31:0] i_dbg_reg_data
);

  int fail_count = 0;

  // stage registers are cleared by reset, so no store follows it
  no_store_in_reset: assert property (@(posedge i_clk) i_rst |=> !i_mem_write)
  else
  begin
    fail_count++;
    $error("data memory write right after a reset cycle");
  end

  // a stall must never keep fetch from taking the target
  redirect_loads_pc: assert property (@(posedge i_clk) disable iff (i_rst)
    i_redirect |=> (i_pc == $past(i_target)))
  else
  begin
    fail_count++;
    $error("fetch did not load the redirect target");
  end

  reg0_reads_zero: assert property (@(posedge i_clk)
    (i_dbg_reg == 5'd0) |-> (i_dbg_reg_data == 32'd0))
  else
  begin
    fail_count++;
    $error("register 0 read a nonzero value");
  end

endmodule

bind mips_core mips_core_chk u_chk
(
  .i_clk          (i_clk),
  .i_rst          (i_rst),
  .i_mem_write    (ex_q.mem_write),
  .i_redirect     (redirect),
  .i_target       (target),
  .i_pc           (o_pc),
  .i_dbg_reg      (i_dbg_reg),
  .i_dbg_reg_data (o_dbg_reg_data)
);

// File: tests/tb_mips_core.sv
`timescale 1ns/10ps

module tb_mips_core;

  localparam int    IMEM_WORDS   = 64;
  localparam int    DMEM_WORDS   = 64;
  localparam int    RUN_CYCLES   = 400;
  localparam string PATTERN_FILE = "tests/mips_patterns.txt";

  logic        clk = 1'b0;
  logic        rst;
  logic        run;
  logic        imem_we;
  logic [5:0]  imem_addr;
  logic [31:0] imem_data;
  logic [4:0]  dbg_reg;
  logic [31:0] dbg_reg_data;
  logic [5:0]  dbg_mem;
  logic [31:0] dbg_mem_data;
  logic [31:0] pc;

  logic [31:0] pat [128];
  int          n_prog;
  int          limit_cycles = 0;
  int          checks = 0;
  int          errors = 0;
  int          assert_fails;

  mips_core #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) uut
  (
    .i_clk          (clk),
    .i_rst          (rst),
    .i_run          (run),
    .i_imem_we      (imem_we),
    .i_imem_addr    (imem_addr),
    .i_imem_data    (imem_data),
    .i_dbg_reg      (dbg_reg),
    .o_dbg_reg_data (dbg_reg_data),
    .i_dbg_mem      (dbg_mem),
    .o_dbg_mem_data (dbg_mem_data),
    .o_pc           (pc)
  );

  always #10 clk = ~clk;

  task automatic compare_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < n_prog; i++)
    begin
      imem_we   = 1'b1;
      imem_addr = 6'(i);
      imem_data = pat[1 + i];
      @(posedge clk);
      #2;
    end
    imem_we = 1'b0;
  endtask

  // the final jump fetches two younger words before it redirects
  task automatic check_pc_loop();
    logic [31:0] loop_pc;
    int          waited;
    loop_pc = 32'((n_prog - 1) * 4);
    waited  = 0;
    while (pc !== loop_pc && waited < 3)
    begin
      @(posedge clk);
      #2;
      waited++;
    end
    compare_word(pc, loop_pc, "pc at the final jump");
    for (int k = 1; k <= 3; k++)
    begin
      @(posedge clk);
      #2;
      compare_word(pc, loop_pc + 32'(4 * (k % 3)), "pc in the final jump loop");
    end
  endtask

  // register entries follow the program words
  task automatic check_registers();
    int base;
    int n_reg;
    base  = n_prog + 1;
    n_reg = int'(pat[base]);
    for (int r = 0; r < n_reg; r++)
    begin
      @(posedge clk);
      #2;
      dbg_reg = pat[base + 1 + 2 * r][4:0];
      #5;
      compare_word(dbg_reg_data, pat[base + 2 + 2 * r], $sformatf("register %0d", dbg_reg));
    end
  endtask

  task automatic check_memory();
    int base;
    int n_mem;
    base  = n_prog + 2 + 2 * int'(pat[n_prog + 1]);
    n_mem = int'(pat[base]);
    for (int m = 0; m < n_mem; m++)
    begin
      @(posedge clk);
      #2;
      dbg_mem = pat[base + 1 + 2 * m][5:0];
      #5;
      compare_word(dbg_mem_data, pat[base + 2 + 2 * m], $sformatf("data word %0d", dbg_mem));
    end
  endtask

  initial
  begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("Test FAILED");
    $finish;
  end

  initial
  begin
    rst       = 1'b1;
    run       = 1'b0;
    imem_we   = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    dbg_reg   = '0;
    dbg_mem   = '0;
    $readmemh(PATTERN_FILE, pat);
    n_prog = int'(pat[0]);
    if (n_prog <= 0 || n_prog > IMEM_WORDS)
    begin
      $display("the pattern file %s is missing or gives a bad program length", PATTERN_FILE);
      errors++;
    end
    else
    begin
      limit_cycles = n_prog * 20 + 1000;
      repeat (3) @(posedge clk);
      #2;
      rst = 1'b0;
      load_program();
      run = 1'b1;
      // programs end in a jump to itself
      repeat (RUN_CYCLES) @(posedge clk);
      #2;
      check_pc_loop();
      check_registers();
      check_memory();
    end
    assert_fails = uut.u_chk.fail_count;
    errors += assert_fails;
    $display("%0d checks, %0d errors, %0d of them from assertions", checks, errors, assert_fails);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// File: tests/mips_patterns.txt
// program length, then one instruction word per line
// then a count of (register value) pairs, then a count of (data word address, value) pairs
1b
20010005 // addi  $1, $0, 5
2002fffd // addi  $2, $0, -3
3c031234 // lui   $3, 0x1234
24645678 // addiu $4, $3, 0x5678
00222820 // add   $5, $1, $2
00223022 // sub   $6, $1, $2
00833824 // and   $7, $4, $3
00234025 // or    $8, $1, $3
0041482a // slt   $9, $2, $1
0022502a // slt   $10, $1, $2
ac040008 // sw    $4, 8($0)
8c0b0008 // lw    $11, 8($0)
01616020 // add   $12, $11, $1
20000007 // addi  $0, $0, 7
200d00aa // addi  $13, $0, 0xaa
200f00bb // addi  $15, $0, 0xbb
10210002 // beq   $1, $1, +2 (taken)
200d0001 // addi  $13, $0, 1 (skipped)
200d0002 // addi  $13, $0, 2 (skipped)
14210001 // bne   $1, $1, +1 (not taken)
200e0055 // addi  $14, $0, 0x55
14220001 // bne   $1, $2, +1 (taken)
200e0066 // addi  $14, $0, 0x66 (skipped)
08000019 // j     25
200f0077 // addi  $15, $0, 0x77 (skipped)
ac0e000c // sw    $14, 12($0)
0800001a // j     26
10
00 00000000  01 00000005  02 fffffffd  03 12340000
04 12345678  05 00000002  06 00000008  07 12340000
08 12340005  09 00000001  0a 00000000  0b 12345678
0c 1234567d  0d 000000aa  0e 00000055  0f 000000bb
02
02 12345678  03 00000055

// File: tb.f
verilog/mips_pkg.sv
verilog/control.sv
verilog/pipe_reg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/mips_core.sv
tests/mips_core_chk.sv
tests/tb_mips_core.sv

// File: Makefile
LOG = sim.log

simulate:
	verilator --binary --timing --assert -j 0 --top-module tb_mips_core -f tb.f -o Vtb_mips_core
	./obj_dir/Vtb_mips_core +verilator+error+limit+100 | tee $(LOG)
	@grep -q "Test OK" $(LOG)
	@! grep -q "Test FAILED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: simulate clean
